// ==== verilog/l2_cache_pkg.sv ====
/* L2 cache shared definitions */

package l2_cache_pkg;
	// Cache geometry
	localparam int L2_WAYS = 4;
	localparam int L2_SETS = 16;
	localparam int TAG_BITS = 8;
	localparam int LINE_BITS = 32;
	localparam int NUM_THREADS = 4;

	// Index widths derived from the geometry
	localparam int SET_BITS = $clog2(L2_SETS);
	localparam int WAY_BITS = $clog2(L2_WAYS);
	localparam int THREAD_BITS = $clog2(NUM_THREADS);
	localparam int ADDR_BITS = TAG_BITS + SET_BITS;

	// The data array holds one line per way and set
	localparam int DATA_ENTRIES = L2_WAYS * L2_SETS;

	// Request operations
	typedef enum logic [2:0]
	{
		L2_LOAD,
		L2_STORE,
		L2_LOAD_SYNC,
		L2_STORE_SYNC,
		L2_FLUSH
	} l2_op_t;

	typedef logic [SET_BITS - 1:0] set_idx_t;
	typedef logic [WAY_BITS - 1:0] way_idx_t;
	typedef logic [TAG_BITS - 1:0] l2_tag_t;

	// Line address with the tag in the upper bits and the set index below it
	typedef logic [ADDR_BITS - 1:0] l2_addr_t;

	typedef logic [THREAD_BITS - 1:0] thread_idx_t;
	typedef logic [LINE_BITS - 1:0] line_t;
endpackage

// ==== verilog/l2_tag_way.sv ====
/* L2 tag way storage */

`timescale 1ns/1ps

module l2_tag_way(
	input logic clk,
	input logic reset,

	// Read port, addressed by the incoming request
	input l2_cache_pkg::set_idx_t read_set,

	// Metadata updates from the read stage
	input logic tag_update_en,
	input logic dirty_update_en,
	input logic dirty_value,
	input l2_cache_pkg::set_idx_t update_set,
	input l2_cache_pkg::l2_tag_t update_tag,

	// Read results, aligned with the registered request
	output logic way_valid,
	output l2_cache_pkg::l2_tag_t way_tag,
	output logic way_dirty);

	import l2_cache_pkg::*;

	// Per-set metadata for this way
	logic [L2_SETS - 1:0] valid_bits;
	l2_tag_t tag_mem[L2_SETS];
	logic dirty_mem[L2_SETS];

	logic tag_bypass;
	logic dirty_bypass;

	// An update that lands on the set being read this edge must be seen by
	// the next request, otherwise back-to-back requests would read stale state
	assign tag_bypass = tag_update_en && update_set == read_set;
	assign dirty_bypass = dirty_update_en && update_set == read_set;

	// After reset every line of this way is empty
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			way_valid <= 1'b0;
		end
		else
		begin
			// Installing a tag always makes the line valid
			if (tag_update_en)
				valid_bits[update_set] <= 1'b1;

			way_valid <= tag_bypass || valid_bits[read_set];
		end
	end

	always_ff @(posedge clk)
	begin
		if (tag_update_en)
			tag_mem[update_set] <= update_tag;

		if (dirty_update_en)
			dirty_mem[update_set] <= dirty_value;

		way_tag <= tag_bypass ? update_tag : tag_mem[read_set];
		way_dirty <= dirty_bypass ? dirty_value : dirty_mem[read_set];
	end

	// A fill installs the tag and initializes the dirty bit of the same
	// entry in one edge, so a newly valid line never exposes an old dirty bit
	assert property (@(posedge clk) disable iff (reset)
		tag_update_en |-> dirty_update_en);
endmodule

// ==== verilog/l2_cache_tag.sv ====
/* L2 cache tag stage */

`timescale 1ns/1ps

module l2_cache_tag(
	input logic clk,
	input logic reset,

	// Incoming request
	input logic req_valid,
	input logic req_fill,
	input l2_cache_pkg::l2_op_t req_op,
	input l2_cache_pkg::thread_idx_t req_thread,
	input l2_cache_pkg::l2_addr_t req_address,
	input l2_cache_pkg::line_t req_data,

	// LRU update from the read stage
	input logic lru_update_en,
	input l2_cache_pkg::set_idx_t lru_update_set,
	input l2_cache_pkg::way_idx_t lru_update_way,

	// Set read by the ways this cycle
	output l2_cache_pkg::set_idx_t way_read_set,

	// Registered request to the read stage
	output logic t_valid,
	output logic t_fill,
	output l2_cache_pkg::l2_op_t t_op,
	output l2_cache_pkg::thread_idx_t t_thread,
	output l2_cache_pkg::l2_addr_t t_address,
	output l2_cache_pkg::line_t t_data,
	output l2_cache_pkg::way_idx_t t_lru_way);

	import l2_cache_pkg::*;

	// Each set keeps its ways ordered from most recent (slot 0) to least
	// recent (last slot)
	way_idx_t lru_order[L2_SETS][L2_WAYS];
	way_idx_t lru_cur[L2_WAYS];
	way_idx_t lru_moved[L2_WAYS];
	logic lru_bypass;
	logic order_is_perm;

	// The set index is the low part of the line address
	assign way_read_set = req_address[SET_BITS - 1:0];
	assign lru_bypass = lru_update_en && lru_update_set == way_read_set;

	always_comb
	begin
		for (int i = 0; i < L2_WAYS; i++)
			lru_cur[i] = lru_order[lru_update_set][i];
	end

	// Move the used way to the front. Every entry ahead of its old slot
	// shifts back by one and the entries behind it stay put
	always_comb
	begin
		logic found;

		found = 1'b0;
		lru_moved[0] = lru_update_way;
		for (int i = 1; i < L2_WAYS; i++)
		begin
			if (lru_cur[i - 1] == lru_update_way)
				found = 1'b1;

			lru_moved[i] = found ? lru_cur[i] : lru_cur[i - 1];
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Way 0 starts most recent and the last way least recent
			for (int s = 0; s < L2_SETS; s++)
			begin
				for (int i = 0; i < L2_WAYS; i++)
					lru_order[s][i] <= way_idx_t'(i);
			end
		end
		else if (lru_update_en)
		begin
			for (int i = 0; i < L2_WAYS; i++)
				lru_order[lru_update_set][i] <= lru_moved[i];
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			t_valid <= 1'b0;
		else
			t_valid <= req_valid;
	end

	// Payload travels alongside t_valid
	always_ff @(posedge clk)
	begin
		t_fill <= req_fill;
		t_op <= req_op;
		t_thread <= req_thread;
		t_address <= req_address;
		t_data <= req_data;

		// Victim candidate, taken from the update when it hits the same set
		if (lru_bypass)
			t_lru_way <= lru_moved[L2_WAYS - 1];
		else
			t_lru_way <= lru_order[way_read_set][L2_WAYS - 1];
	end

	// Every way must appear exactly once in the order being read
	always_comb
	begin
		logic [L2_WAYS - 1:0] seen;

		seen = '0;
		for (int i = 0; i < L2_WAYS; i++)
			seen[lru_order[way_read_set][i]] = 1'b1;

		order_is_perm = &seen;
	end

	assert property (@(posedge clk) disable iff (reset) order_is_perm);
endmodule

// ==== verilog/l2_cache_read.sv ====
/* L2 cache read stage */

`timescale 1ns/1ps

module l2_cache_read(
	input logic clk,
	input logic reset,

	// Registered request from the tag stage
	input logic t_valid,
	input logic t_fill,
	input l2_cache_pkg::l2_op_t t_op,
	input l2_cache_pkg::thread_idx_t t_thread,
	input l2_cache_pkg::l2_addr_t t_address,
	input l2_cache_pkg::line_t t_data,
	input l2_cache_pkg::way_idx_t t_lru_way,

	// Metadata read by the ways
	input logic way_valid[l2_cache_pkg::L2_WAYS],
	input logic way_dirty[l2_cache_pkg::L2_WAYS],
	input l2_cache_pkg::l2_tag_t way_tag[l2_cache_pkg::L2_WAYS],

	// Metadata updates, written at the next edge
	output l2_cache_pkg::set_idx_t update_set,
	output logic [l2_cache_pkg::L2_WAYS - 1:0] tag_update_en,
	output logic [l2_cache_pkg::L2_WAYS - 1:0] dirty_update_en,
	output logic dirty_value,
	output logic lru_update_en,
	output l2_cache_pkg::way_idx_t lru_update_way,

	// Response
	output logic resp_valid,
	output l2_cache_pkg::l2_op_t resp_op,
	output l2_cache_pkg::thread_idx_t resp_thread,
	output l2_cache_pkg::l2_addr_t resp_address,
	output logic resp_hit,
	output l2_cache_pkg::line_t resp_data,
	output logic resp_sync_success,

	// Writeback
	output logic wb_valid,
	output l2_cache_pkg::l2_addr_t wb_address,
	output l2_cache_pkg::line_t wb_data);

	import l2_cache_pkg::*;

	line_t data_mem[DATA_ENTRIES];

	// Synchronized load record per thread
	l2_addr_t sync_addr[NUM_THREADS];
	logic [NUM_THREADS - 1:0] sync_valid;

	set_idx_t t_set;
	l2_tag_t t_tag;
	logic [L2_WAYS - 1:0] tag_match;
	logic cache_hit;
	logic fill;
	way_idx_t hit_way;
	way_idx_t fill_way;
	way_idx_t access_way;
	logic [WAY_BITS + SET_BITS - 1:0] data_idx;
	line_t old_data;
	logic can_store_sync;
	logic store_sync_ok;
	logic data_write;
	logic sync_clear;
	logic fill_wb;
	logic flush_wb;

	assign t_set = t_address[SET_BITS - 1:0];
	assign t_tag = t_address[ADDR_BITS - 1:SET_BITS];
	assign fill = t_valid && t_fill;

	// Raw tag compare, before the fill qualifier
	always_comb
	begin
		for (int w = 0; w < L2_WAYS; w++)
			tag_match[w] = way_valid[w] && way_tag[w] == t_tag;
	end

	assign cache_hit = t_valid && !t_fill && |tag_match;

	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < L2_WAYS; w++)
		begin
			if (tag_match[w])
				hit_way = way_idx_t'(w);
		end
	end

	// Scan downwards so the lowest invalid way wins, else take the LRU way
	always_comb
	begin
		fill_way = t_lru_way;
		for (int w = L2_WAYS - 1; w >= 0; w--)
		begin
			if (!way_valid[w])
				fill_way = way_idx_t'(w);
		end
	end

	assign access_way = fill ? fill_way : hit_way;

	// On a fill this reads the victim line, on a hit the hit line
	assign data_idx = {access_way, t_set};
	assign old_data = data_mem[data_idx];

	// A store-sync only goes through if this thread's record still holds
	// the address, so nobody stored to the line since the load-sync
	assign can_store_sync = t_op == L2_STORE_SYNC && sync_valid[t_thread]
		&& sync_addr[t_thread] == t_address;
	assign store_sync_ok = cache_hit && can_store_sync;

	assign data_write = fill || (cache_hit && (t_op == L2_STORE || store_sync_ok));

	assign update_set = t_set;

	// Dirty is set by stores, cleared by flushes, and set up by every fill
	assign dirty_value = t_op == L2_STORE || t_op == L2_STORE_SYNC;

	always_comb
	begin
		for (int w = 0; w < L2_WAYS; w++)
		begin
			tag_update_en[w] = fill && fill_way == way_idx_t'(w);
			dirty_update_en[w] = access_way == way_idx_t'(w) && (fill || (cache_hit
				&& (t_op == L2_STORE || store_sync_ok || t_op == L2_FLUSH)));
		end
	end

	// Flushes leave the recency order alone
	assign lru_update_en = fill || (cache_hit && t_op != L2_FLUSH);
	assign lru_update_way = access_way;

	// Evicting a dirty valid victim, or flushing a dirty line
	assign fill_wb = fill && way_valid[fill_way] && way_dirty[fill_way];
	assign flush_wb = cache_hit && t_op == L2_FLUSH && way_dirty[hit_way];

	// Any store that lands on the line kills every record of its address
	assign sync_clear = store_sync_ok || (t_op == L2_STORE && (cache_hit || fill));

	always_ff @(posedge clk)
	begin
		if (data_write)
			data_mem[data_idx] <= t_data;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sync_valid <= '0;
			resp_valid <= 1'b0;
			resp_sync_success <= 1'b0;
			wb_valid <= 1'b0;
		end
		else
		begin
			if (sync_clear)
			begin
				for (int i = 0; i < NUM_THREADS; i++)
				begin
					if (sync_addr[i] == t_address)
						sync_valid[i] <= 1'b0;
				end
			end

			if (t_op == L2_LOAD_SYNC && (cache_hit || fill))
				sync_valid[t_thread] <= 1'b1;

			resp_valid <= t_valid;
			resp_sync_success <= store_sync_ok;
			wb_valid <= fill_wb || flush_wb;
		end
	end

	always_ff @(posedge clk)
	begin
		if (t_op == L2_LOAD_SYNC && (cache_hit || fill))
			sync_addr[t_thread] <= t_address;

		resp_op <= t_op;
		resp_thread <= t_thread;
		resp_address <= t_address;
		resp_hit <= cache_hit;

		// Fills answer with the new line, everything else with the old one
		resp_data <= fill ? t_data : old_data;

		wb_address <= fill ? {way_tag[fill_way], t_set} : t_address;
		wb_data <= old_data;
	end

	// The outside only fills lines that miss
	assert property (@(posedge clk) disable iff (reset) fill |-> !(|tag_match));

	assert property (@(posedge clk) disable iff (reset)
		fill |-> t_op != L2_STORE_SYNC && t_op != L2_FLUSH);

	// Fills never install a duplicate tag, so at most one way can match
	assert property (@(posedge clk) disable iff (reset) t_valid |-> $onehot0(tag_match));
endmodule

// ==== verilog/l2_cache.sv ====
/* L2 cache top */

`timescale 1ns/1ps

module l2_cache(
	input logic clk,
	input logic reset,

	// Requests, one per cycle at most
	input logic req_valid,
	input l2_cache_pkg::l2_op_t req_op,
	input logic req_fill,
	input l2_cache_pkg::thread_idx_t req_thread,
	input l2_cache_pkg::l2_addr_t req_address,
	input l2_cache_pkg::line_t req_data,

	// Responses, two cycles after the request
	output logic resp_valid,
	output l2_cache_pkg::l2_op_t resp_op,
	output l2_cache_pkg::thread_idx_t resp_thread,
	output l2_cache_pkg::l2_addr_t resp_address,
	output logic resp_hit,
	output l2_cache_pkg::line_t resp_data,
	output logic resp_sync_success,

	// Writebacks to memory
	output logic wb_valid,
	output l2_cache_pkg::l2_addr_t wb_address,
	output l2_cache_pkg::line_t wb_data);

	import l2_cache_pkg::*;

	set_idx_t way_read_set;
	logic t_valid;
	logic t_fill;
	l2_op_t t_op;
	thread_idx_t t_thread;
	l2_addr_t t_address;
	line_t t_data;
	way_idx_t t_lru_way;

	logic way_valid[L2_WAYS];
	logic way_dirty[L2_WAYS];
	l2_tag_t way_tag[L2_WAYS];

	set_idx_t update_set;
	logic [L2_WAYS - 1:0] tag_update_en;
	logic [L2_WAYS - 1:0] dirty_update_en;
	logic dirty_value;
	logic lru_update_en;
	way_idx_t lru_update_way;

	l2_cache_tag tag_stage(
		.lru_update_set(update_set),
		.*);

	// One metadata store per way, all sharing the update set and the
	// tag of the request in the read stage
	genvar way;
	generate
		for (way = 0; way < L2_WAYS; way++)
		begin : way_gen
			l2_tag_way tag_way(
				.clk(clk),
				.reset(reset),
				.read_set(way_read_set),
				.tag_update_en(tag_update_en[way]),
				.dirty_update_en(dirty_update_en[way]),
				.dirty_value(dirty_value),
				.update_set(update_set),
				.update_tag(t_address[ADDR_BITS - 1:SET_BITS]),
				.way_valid(way_valid[way]),
				.way_tag(way_tag[way]),
				.way_dirty(way_dirty[way]));
		end
	endgenerate

	l2_cache_read read_stage(.*);
endmodule

// ==== sim/tb_clock_gen.sv ====
/* Testbench clock and reset */

`timescale 1ns/1ps

module tb_clock_gen(
	output logic clk,
	output logic reset);

	// 100 ns period, starting low
	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Reset is held over the first three rising edges and released at the third
	initial
	begin
		reset = 1'b1;
		repeat (3)
			@(posedge clk);
		reset <= 1'b0;
	end
endmodule

// ==== sim/l2_cache_tb.sv ====
/* L2 cache testbench */

`timescale 1ns/1ps

module l2_cache_tb;
	import l2_cache_pkg::*;

	localparam int NUM_REQUESTS = 2000;
	localparam int RESET_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT = 10;

	// What the DUT must show for one issued request, and the cycle it is due
	typedef struct packed
	{
		int due;
		l2_op_t op;
		thread_idx_t thread;
		l2_addr_t address;
		logic hit;
		logic sync_ok;
		logic data_known;
		line_t data;
		logic wb;
		l2_addr_t wb_address;
		line_t wb_data;
	} expect_t;

	logic clk;
	logic reset;
	logic req_valid;
	l2_op_t req_op;
	logic req_fill;
	thread_idx_t req_thread;
	l2_addr_t req_address;
	line_t req_data;
	logic resp_valid;
	l2_op_t resp_op;
	thread_idx_t resp_thread;
	l2_addr_t resp_address;
	logic resp_hit;
	line_t resp_data;
	logic resp_sync_success;
	logic wb_valid;
	l2_addr_t wb_address;
	line_t wb_data;

	// Reference model of the cache contents, recency order and sync records
	l2_tag_t m_tag[L2_SETS][L2_WAYS];
	logic m_valid[L2_SETS][L2_WAYS];
	logic m_dirty[L2_SETS][L2_WAYS];
	line_t m_data[L2_SETS][L2_WAYS];
	way_idx_t m_order[L2_SETS][L2_WAYS];
	l2_addr_t m_sync_addr[NUM_THREADS];
	logic m_sync_valid[NUM_THREADS];

	expect_t exp_q[$];
	l2_tag_t tag_pool[6];
	int seed;
	l2_addr_t last_sync_addr;
	thread_idx_t last_sync_thread;
	set_idx_t last_set;
	int n_hit;
	int n_fill;
	int n_wb;
	int n_sync_ok;
	int n_sync_fail;

	tb_clock_gen clock_gen(.clk(clk), .reset(reset));

	l2_cache DUT(.*);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_resp(input l2_op_t op, input thread_idx_t thread,
		input l2_addr_t address, input logic hit, input logic sync_ok, input line_t data,
		input logic data_known);
		if (resp_op !== op)
			report_error($sformatf("MISMATCH resp_op expected %h got %h", op, resp_op));
		if (resp_thread !== thread)
			report_error($sformatf("MISMATCH resp_thread expected %h got %h", thread,
				resp_thread));
		if (resp_address !== address)
			report_error($sformatf("MISMATCH resp_address expected %h got %h", address,
				resp_address));
		if (resp_hit !== hit)
			report_error($sformatf("MISMATCH resp_hit expected %h got %h", hit, resp_hit));
		if (resp_sync_success !== sync_ok)
			report_error($sformatf("MISMATCH resp_sync_success expected %h got %h", sync_ok,
				resp_sync_success));

		// A miss without a fill carries no defined line
		if (data_known && resp_data !== data)
			report_error($sformatf("MISMATCH resp_data expected %h got %h", data, resp_data));
	endtask

	task automatic check_writeback(input l2_addr_t address, input line_t data);
		if (wb_address !== address)
			report_error($sformatf("MISMATCH wb_address expected %h got %h", address,
				wb_address));
		if (wb_data !== data)
			report_error($sformatf("MISMATCH wb_data expected %h got %h", data, wb_data));
	endtask

	// Matches the state of the DUT right after reset
	task automatic reset_model();
		for (int s = 0; s < L2_SETS; s++)
		begin
			for (int w = 0; w < L2_WAYS; w++)
			begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_tag[s][w] = '0;
				m_data[s][w] = '0;
				m_order[s][w] = way_idx_t'(w);
			end
		end
		for (int t = 0; t < NUM_THREADS; t++)
		begin
			m_sync_valid[t] = 1'b0;
			m_sync_addr[t] = '0;
		end
		// Six tags over four ways keep hits and evictions both common
		tag_pool = '{8'h00, 8'h3c, 8'h5a, 8'h81, 8'hc3, 8'hff};
		seed = 32'hf082_3f79;
		last_sync_addr = '0;
		last_sync_thread = '0;
		last_set = '0;
		n_hit = 0;
		n_fill = 0;
		n_wb = 0;
		n_sync_ok = 0;
		n_sync_fail = 0;
	endtask

	// Way holding a valid copy of the tag, or -1 on a miss
	function automatic int find_way(input set_idx_t idx, input l2_tag_t tag);
		int way;

		way = -1;
		for (int w = 0; w < L2_WAYS; w++)
		begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag)
				way = w;
		end
		return way;
	endfunction

	function automatic int choose_fill_way(input set_idx_t idx);
		int way;

		// Any empty way is taken before the least recent one is evicted
		way = int'(m_order[idx][L2_WAYS - 1]);
		for (int w = 0; w < L2_WAYS; w++)
		begin
			if (!m_valid[idx][w])
			begin
				way = w;
				break;
			end
		end
		return way;
	endfunction

	task automatic move_to_front(input set_idx_t idx, input int way);
		int pos;

		pos = 0;
		for (int i = 0; i < L2_WAYS; i++)
		begin
			if (int'(m_order[idx][i]) == way)
				pos = i;
		end
		for (int i = pos; i > 0; i--)
			m_order[idx][i] = m_order[idx][i - 1];
		m_order[idx][0] = way_idx_t'(way);
	endtask

	// A store to a line kills every thread's record of it
	task automatic clear_sync(input l2_addr_t address);
		for (int t = 0; t < NUM_THREADS; t++)
		begin
			if (m_sync_addr[t] == address)
				m_sync_valid[t] = 1'b0;
		end
	endtask

	task automatic model_request(input l2_op_t op, input logic fill, input thread_idx_t thread,
		input l2_addr_t address, input line_t data, input int due);
		set_idx_t idx;
		int way;
		expect_t e;

		idx = address[SET_BITS - 1:0];
		way = find_way(idx, address[ADDR_BITS - 1:SET_BITS]);
		e.due = due;
		e.op = op;
		e.thread = thread;
		e.address = address;
		e.hit = !fill && way >= 0;
		e.sync_ok = 1'b0;
		e.data_known = fill || way >= 0;
		e.data = '0;
		e.wb = 1'b0;
		e.wb_address = '0;
		e.wb_data = '0;

		if (fill)
		begin
			way = choose_fill_way(idx);
			// A dirty victim goes back to memory before it is replaced
			if (m_valid[idx][way] && m_dirty[idx][way])
			begin
				e.wb = 1'b1;
				e.wb_address = {m_tag[idx][way], idx};
				e.wb_data = m_data[idx][way];
			end
			m_tag[idx][way] = address[ADDR_BITS - 1:SET_BITS];
			m_valid[idx][way] = 1'b1;
			m_dirty[idx][way] = op == L2_STORE;
			m_data[idx][way] = data;
			e.data = data;
			if (op == L2_STORE)
				clear_sync(address);
			if (op == L2_LOAD_SYNC)
			begin
				m_sync_addr[thread] = address;
				m_sync_valid[thread] = 1'b1;
			end
			move_to_front(idx, way);
			n_fill++;
		end
		else if (way >= 0)
		begin
			e.data = m_data[idx][way];
			case (op)
				L2_STORE:
				begin
					m_data[idx][way] = data;
					m_dirty[idx][way] = 1'b1;
					clear_sync(address);
				end
				L2_STORE_SYNC:
				begin
					if (m_sync_valid[thread] && m_sync_addr[thread] == address)
					begin
						e.sync_ok = 1'b1;
						m_data[idx][way] = data;
						m_dirty[idx][way] = 1'b1;
						clear_sync(address);
						n_sync_ok++;
					end
					else
						n_sync_fail++;
				end
				L2_LOAD_SYNC:
				begin
					m_sync_addr[thread] = address;
					m_sync_valid[thread] = 1'b1;
				end
				L2_FLUSH:
				begin
					if (m_dirty[idx][way])
					begin
						e.wb = 1'b1;
						e.wb_address = address;
						e.wb_data = m_data[idx][way];
					end
					m_dirty[idx][way] = 1'b0;
				end
				default:
				begin
				end
			endcase
			// Flushes keep the recency order as it was
			if (op != L2_FLUSH)
				move_to_front(idx, way);
			n_hit++;
		end

		if (e.wb)
			n_wb++;
		exp_q.push_back(e);
	endtask

	function automatic l2_op_t pick_op(input logic [2:0] code);
		case (code)
			3'd0, 3'd1: return L2_LOAD;
			3'd2, 3'd3: return L2_STORE;
			3'd4, 3'd7: return L2_LOAD_SYNC;
			3'd5: return L2_STORE_SYNC;
			default: return L2_FLUSH;
		endcase
	endfunction

	task automatic issue_request(input int cycle, output logic sent);
		logic [31:0] r;
		l2_op_t op;
		thread_idx_t thread;
		set_idx_t idx;
		l2_addr_t address;
		line_t data;
		logic fill;

		r = $random(seed);
		data = $random(seed);
		// About one cycle in four stays idle
		sent = r[31:30] != 2'b00;
		op = pick_op(r[2:0]);
		thread = r[4:3];
		// Half the requests reuse the previous set to exercise the bypass paths
		idx = r[5] ? last_set : r[9:6];
		address = {tag_pool[int'(r[17:10]) % 6], idx};

		// Most store-syncs go after the latest load-sync so some of them succeed
		if (op == L2_STORE_SYNC && r[19:18] != 2'b00)
		begin
			thread = last_sync_thread;
			address = last_sync_addr;
		end

		// Only misses are filled, and never by a store-sync or a flush
		fill = sent && op != L2_STORE_SYNC && op != L2_FLUSH && r[21:20] != 2'b00
			&& find_way(address[SET_BITS - 1:0], address[ADDR_BITS - 1:SET_BITS]) < 0;

		req_valid <= sent;
		req_op <= op;
		req_fill <= fill;
		req_thread <= thread;
		req_address <= address;
		req_data <= data;

		if (sent)
		begin
			last_set = address[SET_BITS - 1:0];
			if (op == L2_LOAD_SYNC)
			begin
				last_sync_addr = address;
				last_sync_thread = thread;
			end
			// Driven now, sampled next edge, answered two edges after that
			model_request(op, fill, thread, address, data, cycle + 3);
		end
	endtask

	// Outputs are read at the edge, before the DUT updates them
	task automatic sample_outputs(input int cycle);
		expect_t e;

		if (exp_q.size() > 0 && exp_q[0].due == cycle)
		begin
			e = exp_q.pop_front();
			if (resp_valid !== 1'b1)
				report_error($sformatf("MISMATCH resp_valid expected 1 got %h", resp_valid));
			check_resp(e.op, e.thread, e.address, e.hit, e.sync_ok, e.data, e.data_known);
			if (wb_valid !== e.wb)
				report_error($sformatf("MISMATCH wb_valid expected %h got %h", e.wb, wb_valid));
			if (e.wb)
				check_writeback(e.wb_address, e.wb_data);
		end
		else
		begin
			if (resp_valid !== 1'b0)
				report_error($sformatf("MISMATCH resp_valid expected 0 got %h", resp_valid));
			if (wb_valid !== 1'b0)
				report_error($sformatf("MISMATCH wb_valid expected 0 got %h", wb_valid));
		end
	endtask

	initial
	begin
		int cycle;
		int issued;
		int wait_count;
		logic sent;

		reset_model();
		req_valid <= 1'b0;
		req_op <= L2_LOAD;
		req_fill <= 1'b0;
		req_thread <= '0;
		req_address <= '0;
		req_data <= '0;

		wait_count = 0;
		@(posedge clk);
		while (reset !== 1'b0 && wait_count < RESET_TIMEOUT)
		begin
			@(posedge clk);
			wait_count++;
		end
		if (reset !== 1'b0)
			report_error("Reset did not deassert within the timeout");

		cycle = 0;
		issued = 0;
		while (issued < NUM_REQUESTS)
		begin
			sample_outputs(cycle);
			issue_request(cycle, sent);
			if (sent)
				issued++;
			@(posedge clk);
			cycle++;
		end

		// Let the last requests drain through both stages
		req_valid <= 1'b0;
		req_fill <= 1'b0;
		wait_count = 0;
		while (exp_q.size() > 0 && wait_count < DRAIN_TIMEOUT)
		begin
			sample_outputs(cycle);
			@(posedge clk);
			cycle++;
			wait_count++;
		end

		if (exp_q.size() > 0)
			report_error("Responses were still outstanding after the drain timeout");
		else if (n_hit == 0 || n_fill == 0 || n_wb == 0 || n_sync_ok == 0 || n_sync_fail == 0)
			report_error("Random stimulus never reached hits, fills, writebacks and syncs");
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end
endmodule

// ==== l2_cache.f ====
verilog/l2_cache_pkg.sv
verilog/l2_tag_way.sv
verilog/l2_cache_tag.sv
verilog/l2_cache_read.sv
verilog/l2_cache.sv
sim/tb_clock_gen.sv
sim/l2_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the L2 cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module l2_cache_tb \
	-f l2_cache.f --Mdir obj_dir -o l2_cache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/l2_cache_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
	exit 0
fi

echo "Pass message not found in the simulation output"
exit 1
